// File: Bender.yml
package:
  name: mips_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/mips_pkg.sv
      - hw/fetch_unit.sv
      - hw/decode_control.sv
      - hw/regfile.sv
      - hw/execute_alu.sv
      - hw/data_mem.sv
      - hw/mips_core.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - bench/mips_assert.sv
      - bench/mips_tb.sv

// File: bench/mips_assert.sv
// Concurrent assertions on the observation ports of mips_core, and their bind.
`timescale 1ns/1ps
`include "mips_defines.svh"
`default_nettype none

module mips_assert (
    input logic             clk,
    input logic             reset_i,
    input mips_pkg::word_t  pc_i,
    input mips_pkg::wb_t    wb_i,
    input mips_pkg::store_t store_i
);

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset_i) pc_i[1:0] == 2'b00)
        else $error("pc_o is not word-aligned.");

    // r0 writes never reach the write-back port.
    a_wb_rd_nonzero: assert property (@(posedge clk) wb_i.valid |-> wb_i.rd != 5'd0)
        else $error("wb_o.valid set with rd equal to zero.");

    a_quiet_in_reset: assert property (@(posedge clk)
        reset_i |-> !wb_i.valid && !store_i.valid)
        else $error("A strobe was set while reset_i was high.");

    a_pc_after_reset: assert property (@(posedge clk)
        $fell(reset_i) |-> pc_i == `MIPS_RESET_PC)
        else $error("pc_o is not the reset PC in the cycle after reset.");

endmodule

bind mips_core mips_assert u_assert (
    .clk     (clk),
    .reset_i (reset_i),
    .pc_i    (pc_o),
    .wb_i    (wb_o),
    .store_i (store_o)
);

`default_nettype wire

// File: bench/mips_tb.sv
// Testbench for mips_core with a random program generator, an instruction-level model and checks.
`timescale 1ns/1ps
`include "mips_defines.svh"
`default_nettype none

module mips_tb;
    import mips_pkg::*;

    localparam int PROG_LEN   = 60;
    localparam int NUM_REGS   = 8;  // A small register window keeps operands dependent.
    localparam int DATA_WORDS = 16; // Few data words, so loads often hit earlier stores.
    localparam int MAX_CYCLES = 200;

    logic       clk;
    logic       reset_i;
    imem_load_t imem_load_i;
    word_t      pc_o;
    wb_t        wb_o;
    store_t     store_o;

    integer seed;
    word_t  prog [PROG_LEN];
    word_t  model_regs [32];
    word_t  model_mem [`MIPS_DMEM_DEPTH];
    word_t  model_pc;

    mips_core u_dut (
        .clk         (clk),
        .reset_i     (reset_i),
        .imem_load_i (imem_load_i),
        .pc_o        (pc_o),
        .wb_o        (wb_o),
        .store_o     (store_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    task automatic report_mismatch(input string what);
        $display("[ERROR] t=%0t: %s", $time, what);
        $display("*** TEST FAILED ***");
        $fatal(1, "Core output differs from the model.");
    endtask

    task automatic check_pc(input word_t got, input word_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("pc_o 0x%08h, expected 0x%08h", got, exp));
        end
    endtask

    task automatic check_wb(input wb_t got, input wb_t exp);
        if (got.valid !== exp.valid) begin
            report_mismatch($sformatf("wb_o.valid %b, expected %b at pc 0x%08h",
                                      got.valid, exp.valid, model_pc));
        end else if (exp.valid && (got.rd !== exp.rd || got.data !== exp.data)) begin
            report_mismatch($sformatf("write-back r%0d = 0x%08h, expected r%0d = 0x%08h",
                                      got.rd, got.data, exp.rd, exp.data));
        end
    endtask

    task automatic check_store(input store_t got, input store_t exp);
        if (got.valid !== exp.valid) begin
            report_mismatch($sformatf("store_o.valid %b, expected %b at pc 0x%08h",
                                      got.valid, exp.valid, model_pc));
        end else if (exp.valid && (got.addr !== exp.addr || got.data !== exp.data)) begin
            report_mismatch($sformatf("store [0x%08h] = 0x%08h, expected [0x%08h] = 0x%08h",
                                      got.addr, got.data, exp.addr, exp.data));
        end
    endtask

    // During reset the PC sits at its reset value and both strobes stay low.
    task automatic check_idle();
        wb_t    no_wb;
        store_t no_st;
        no_wb = '0;
        no_st = '0;
        check_pc(pc_o, `MIPS_RESET_PC);
        check_wb(wb_o, no_wb);
        check_store(store_o, no_st);
    endtask

    task automatic gen_program();
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [15:0] imm;
        logic [15:0] offs;
        int          span;
        int          tgt;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            rs   = reg_addr_t'(rand_below(NUM_REGS));
            rt   = reg_addr_t'(rand_below(NUM_REGS));
            rd   = reg_addr_t'(rand_below(NUM_REGS));
            imm  = 16'(rand_below(65536));
            offs = 16'(rand_below(DATA_WORDS) * 4);
            span = (PROG_LEN - 1 - i > 4) ? 4 : PROG_LEN - 1 - i;
            tgt  = i + 1 + rand_below(span); // Always forward, short skips.
            case (rand_below(12))
                0:       prog[i] = {`OP_RTYPE, rs, rt, rd, 5'd0, `FN_ADDU};
                1:       prog[i] = {`OP_RTYPE, rs, rt, rd, 5'd0, `FN_SUBU};
                2:       prog[i] = {`OP_RTYPE, rs, rt, rd, 5'd0, `FN_AND};
                3:       prog[i] = {`OP_RTYPE, rs, rt, rd, 5'd0, `FN_OR};
                4:       prog[i] = {`OP_RTYPE, rs, rt, rd, 5'd0, `FN_SLT};
                5:       prog[i] = {`OP_ADDIU, rs, rt, imm};
                6:       prog[i] = {`OP_ANDI, rs, rt, imm};
                7:       prog[i] = {`OP_ORI, rs, rt, imm};
                8:       prog[i] = {`OP_LW, 5'd0, rt, offs};
                9:       prog[i] = {`OP_SW, 5'd0, rt, offs};
                10:      prog[i] = {`OP_BEQ, rs, rt, 16'(tgt - i - 1)};
                default: prog[i] = {`OP_J, 26'(tgt)};
            endcase
        end
        prog[PROG_LEN-1] = {`OP_J, 26'(PROG_LEN - 1)};
    endtask

    // Executes the instruction at model_pc on the model state.
    task automatic model_step(output wb_t exp_wb, output store_t exp_st, output word_t next_pc);
        word_t     instr;
        word_t     a;
        word_t     b;
        word_t     imm_s;
        word_t     imm_z;
        word_t     res;
        word_t     addr;
        word_t     pc_seq;
        reg_addr_t dest;
        logic      wr;
        instr  = prog[int'(model_pc >> 2)];
        a      = model_regs[instr[25:21]];
        b      = model_regs[instr[20:16]];
        imm_s  = {{16{instr[15]}}, instr[15:0]};
        imm_z  = {16'h0000, instr[15:0]};
        addr   = a + imm_s;
        pc_seq = model_pc + 32'd4;
        next_pc = pc_seq;
        dest   = instr[20:16];
        wr     = 1'b1;
        res    = '0;
        exp_wb = '0;
        exp_st = '0;
        case (instr[31:26])
            `OP_RTYPE: begin
                dest = instr[15:11];
                case (instr[5:0])
                    `FN_ADDU: res = a + b;
                    `FN_SUBU: res = a - b;
                    `FN_AND:  res = a & b;
                    `FN_OR:   res = a | b;
                    `FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:  wr = 1'b0;
                endcase
            end
            `OP_ADDIU: res = a + imm_s;
            `OP_ANDI:  res = a & imm_z;
            `OP_ORI:   res = a | imm_z;
            `OP_LW:    res = model_mem[int'((addr >> 2) % `MIPS_DMEM_DEPTH)];
            `OP_SW: begin
                wr           = 1'b0;
                exp_st.valid = 1'b1;
                exp_st.addr  = addr;
                exp_st.data  = b;
                model_mem[int'((addr >> 2) % `MIPS_DMEM_DEPTH)] = b;
            end
            `OP_BEQ: begin
                wr = 1'b0;
                if (a == b) begin
                    next_pc = pc_seq + (imm_s << 2);
                end
            end
            `OP_J: begin
                wr      = 1'b0;
                next_pc = {pc_seq[31:28], instr[25:0], 2'b00};
            end
            default: wr = 1'b0;
        endcase
        if (wr && dest != 5'd0) begin
            exp_wb.valid = 1'b1;
            exp_wb.rd    = dest;
            exp_wb.data  = res;
            model_regs[dest] = res;
        end
    endtask

    initial begin
        imem_load_t load;
        wb_t        exp_wb;
        store_t     exp_st;
        word_t      next_pc;
        int         cycles;
        logic       done;

        seed        = 32'he052_b009;
        reset_i     = 1'b1;
        imem_load_i = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < `MIPS_DMEM_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        gen_program();

        // The program is written while the core is in reset, then two plain reset cycles follow.
        for (int i = 0; i < PROG_LEN + 2; i++) begin
            @(posedge clk);
            load = '0;
            if (i < PROG_LEN) begin
                load.valid = 1'b1;
                load.addr  = word_t'(i * 4);
                load.data  = prog[i];
            end
            imem_load_i <= load;
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        reset_i <= 1'b0;

        model_pc = `MIPS_RESET_PC;
        cycles   = 0;
        done     = 1'b0;
        while (!done && cycles < MAX_CYCLES) begin
            @(negedge clk);
            model_step(exp_wb, exp_st, next_pc);
            check_pc(pc_o, model_pc);
            check_wb(wb_o, exp_wb);
            check_store(store_o, exp_st);
            done     = (next_pc == model_pc); // The self-jump ends the program.
            model_pc = next_pc;
            cycles++;
        end

        if (done) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("Timeout: the program did not reach its final self-jump in %0d cycles.",
                     MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $fatal(1, "Timeout waiting for the end of the program.");
        end
    end

endmodule

`default_nettype wire

// File: hw/data_mem.sv
// Word-addressed data memory with asynchronous read and synchronous write.
`timescale 1ns/1ps
`include "mips_defines.svh"
`default_nettype none

module data_mem (
    input  logic            clk,
    input  logic            we_i,
    input  mips_pkg::word_t addr_i,
    input  mips_pkg::word_t wdata_i,
    output mips_pkg::word_t rdata_o
);
    import mips_pkg::*;

    localparam int DMEM_AW = $clog2(`MIPS_DMEM_DEPTH);

    word_t mem [`MIPS_DMEM_DEPTH];
    logic [DMEM_AW-1:0] idx;

    initial begin
        for (int i = 0; i < `MIPS_DMEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    assign idx = addr_i[DMEM_AW+1:2]; // Byte offset dropped, upper bits wrap.

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[idx] <= wdata_i;
        end
    end

    assign rdata_o = mem[idx];

endmodule

`default_nettype wire

// File: hw/decode_control.sv
// Instruction field extraction, immediate extension and control decode.
`timescale 1ns/1ps
`include "mips_defines.svh"
`default_nettype none

module decode_control (
    input  mips_pkg::word_t     instr_i,
    output mips_pkg::reg_addr_t rs_o,
    output mips_pkg::reg_addr_t rt_o,
    output mips_pkg::reg_addr_t rd_o,
    output mips_pkg::word_t     sign_imm_o,
    output mips_pkg::ctrl_t     ctrl_o
);
    import mips_pkg::*;

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    ctrl_t     ctrl;

    assign opcode = instr_i[31:26];
    assign rs     = instr_i[25:21];
    assign rt     = instr_i[20:16];
    assign rd     = instr_i[15:11];
    assign funct  = instr_i[5:0];

    always_comb begin
        ctrl = '0; // Unknown encodings fall through as no-ops.
        case (opcode)
            `OP_RTYPE: begin
                ctrl.reg_dst = 1'b1;
                ctrl.reg_wr  = 1'b1;
                case (funct)
                    `FN_ADDU: ctrl.alu_op = ADD;
                    `FN_SUBU: ctrl.alu_op = SUB;
                    `FN_AND:  ctrl.alu_op = AND;
                    `FN_OR:   ctrl.alu_op = OR;
                    `FN_SLT:  ctrl.alu_op = SLT;
                    default:  ctrl = '0;
                endcase
            end
            `OP_ADDIU: begin
                ctrl.alu_src  = 1'b1;
                ctrl.reg_wr   = 1'b1;
                ctrl.sign_ext = 1'b1;
                ctrl.alu_op   = ADD;
            end
            `OP_ANDI: begin
                ctrl.alu_src = 1'b1;
                ctrl.reg_wr  = 1'b1;
                ctrl.alu_op  = AND;
            end
            `OP_ORI: begin
                ctrl.alu_src = 1'b1;
                ctrl.reg_wr  = 1'b1;
                ctrl.alu_op  = OR;
            end
            `OP_LW: begin
                ctrl.alu_src    = 1'b1;
                ctrl.reg_wr     = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.sign_ext   = 1'b1;
                ctrl.alu_op     = ADD;
            end
            `OP_SW: begin
                ctrl.alu_src  = 1'b1;
                ctrl.mem_wr   = 1'b1;
                ctrl.sign_ext = 1'b1;
                ctrl.alu_op   = ADD;
            end
            `OP_BEQ: begin
                ctrl.branch   = 1'b1;   // Taken when rs - rt is zero.
                ctrl.sign_ext = 1'b1;
                ctrl.alu_op   = SUB;
            end
            `OP_J: begin
                ctrl.jump = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    // andi and ori take the immediate zero-extended.
    assign sign_imm_o = ctrl.sign_ext ? {{16{instr_i[15]}}, instr_i[15:0]}
                                      : {16'h0000, instr_i[15:0]};

    assign rs_o   = rs;
    assign rt_o   = rt;
    assign rd_o   = ctrl.reg_dst ? rd : rt;
    assign ctrl_o = ctrl;

endmodule

`default_nettype wire

// File: hw/execute_alu.sv
// ALU operand selection, result and zero flag.
`timescale 1ns/1ps
`default_nettype none

module execute_alu (
    input  mips_pkg::ctrl_t ctrl_i,
    input  mips_pkg::word_t opr_a_i,
    input  mips_pkg::word_t rdata2_i,
    input  mips_pkg::word_t sign_imm_i,
    output mips_pkg::word_t res_o,
    output logic            zero_o
);
    import mips_pkg::*;

    word_t opr_b;
    word_t res;

    assign opr_b = ctrl_i.alu_src ? sign_imm_i : rdata2_i;

    always_comb begin
        case (ctrl_i.alu_op)
            ADD:     res = opr_a_i + opr_b;
            SUB:     res = opr_a_i - opr_b;
            AND:     res = opr_a_i & opr_b;
            OR:      res = opr_a_i | opr_b;
            SLT:     res = {31'd0, $signed(opr_a_i) < $signed(opr_b)};
            default: res = '0;
        endcase
    end

    assign res_o  = res;
    assign zero_o = (res == '0); // Branch compare for beq.

endmodule

`default_nettype wire

// File: hw/fetch_unit.sv
// Program counter, next-PC selection and loadable instruction memory.
`timescale 1ns/1ps
`include "mips_defines.svh"
`default_nettype none

module fetch_unit (
    input  logic                 clk,
    input  logic                 reset_i,
    input  mips_pkg::imem_load_t imem_load_i,
    input  mips_pkg::ctrl_t      ctrl_i,
    input  logic                 zero_i,
    input  mips_pkg::word_t      sign_imm_i,
    output mips_pkg::word_t      pc_o,
    output mips_pkg::word_t      instr_o
);
    import mips_pkg::*;

    localparam int IMEM_AW = $clog2(`MIPS_IMEM_DEPTH);

    word_t pc_q;
    word_t pc_next;
    word_t pc_seq;
    word_t pc_branch;
    word_t pc_jump;
    word_t instr;

    word_t imem [`MIPS_IMEM_DEPTH];

    // Loading writes one word per clock, normally while the core is in reset.
    always_ff @(posedge clk) begin
        if (imem_load_i.valid) begin
            imem[imem_load_i.addr[IMEM_AW+1:2]] <= imem_load_i.data;
        end
    end

    assign instr = imem[pc_q[IMEM_AW+1:2]]; // Wraps modulo the depth.

    assign pc_seq    = pc_q + 32'd4;
    assign pc_branch = pc_seq + {sign_imm_i[29:0], 2'b00};

    // Region bits of the sequential PC on top, then the word target.
    assign pc_jump = {pc_seq[31:28], instr[25:0], 2'b00};

    always_comb begin
        if (ctrl_i.jump) begin
            pc_next = pc_jump;
        end else if (ctrl_i.branch && zero_i) begin
            pc_next = pc_branch;
        end else begin
            pc_next = pc_seq;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= `MIPS_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o    = pc_q;
    assign instr_o = instr;

endmodule

`default_nettype wire

// File: hw/mips_core.sv
// Single-cycle core top level with write-back, store and PC observation ports.
`timescale 1ns/1ps
`default_nettype none

module mips_core (
    input  logic                 clk,
    input  logic                 reset_i,
    input  mips_pkg::imem_load_t imem_load_i,
    output mips_pkg::word_t      pc_o,
    output mips_pkg::wb_t        wb_o,
    output mips_pkg::store_t     store_o
);
    import mips_pkg::*;

    word_t     instr;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    word_t     sign_imm;
    ctrl_t     ctrl;
    word_t     rdata1;
    word_t     rdata2;
    word_t     alu_res;
    logic      zero;
    word_t     mem_rdata;
    word_t     wb_data;
    logic      store_en;

    fetch_unit u_fetch (
        .clk         (clk),
        .reset_i     (reset_i),
        .imem_load_i (imem_load_i),
        .ctrl_i      (ctrl),
        .zero_i      (zero),
        .sign_imm_i  (sign_imm),
        .pc_o        (pc_o),
        .instr_o     (instr)
    );

    decode_control u_decode (
        .instr_i    (instr),
        .rs_o       (rs),
        .rt_o       (rt),
        .rd_o       (rd),
        .sign_imm_o (sign_imm),
        .ctrl_o     (ctrl)
    );

    regfile u_regfile (
        .clk      (clk),
        .reset_i  (reset_i),
        .we_i     (ctrl.reg_wr),
        .waddr_i  (rd),
        .wdata_i  (wb_data),
        .raddr1_i (rs),
        .raddr2_i (rt),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    execute_alu u_alu (
        .ctrl_i     (ctrl),
        .opr_a_i    (rdata1),
        .rdata2_i   (rdata2),
        .sign_imm_i (sign_imm),
        .res_o      (alu_res),
        .zero_o     (zero)
    );

    // Stores are held off while the core is in reset.
    assign store_en = ctrl.mem_wr && !reset_i;

    data_mem u_dmem (
        .clk     (clk),
        .we_i    (store_en),
        .addr_i  (alu_res),
        .wdata_i (rdata2),
        .rdata_o (mem_rdata)
    );

    assign wb_data = ctrl.mem_to_reg ? mem_rdata : alu_res;

    assign wb_o.valid = ctrl.reg_wr && (rd != 5'd0) && !reset_i; // r0 writes are dropped.
    assign wb_o.rd    = rd;
    assign wb_o.data  = wb_data;

    assign store_o.valid = store_en;
    assign store_o.addr  = alu_res;
    assign store_o.data  = rdata2;

endmodule

`default_nettype wire

// File: hw/mips_defines.svh
// Memory depths, reset PC and the opcode and funct encodings of the core.
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

`default_nettype none

`define MIPS_IMEM_DEPTH 256
`define MIPS_DMEM_DEPTH 256
`define MIPS_RESET_PC   32'h0000_0000

// Primary opcodes.
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_BEQ   6'h04
`define OP_ADDIU 6'h09
`define OP_ANDI  6'h0c
`define OP_ORI   6'h0d
`define OP_LW    6'h23
`define OP_SW    6'h2b

// Function codes for R-type instructions.
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_SLT  6'h2a

`default_nettype wire

`endif

// File: hw/mips_pkg.sv
// Word and field types, ALU operation codes and the control, load, write-back and store structs.
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        SLT = 3'd4
    } alu_op_t;

    typedef struct packed {
        logic    reg_dst;     // Write rd instead of rt.
        logic    jump;
        logic    branch;
        logic    mem_to_reg;
        logic    mem_wr;
        logic    alu_src;     // ALU B operand comes from the immediate.
        logic    reg_wr;
        logic    sign_ext;
        alu_op_t alu_op;
    } ctrl_t;

    // The load port gives a byte address in addr.
    typedef struct packed {
        logic  valid;
        word_t addr;
        word_t data;
    } imem_load_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    typedef struct packed {
        logic  valid;
        word_t addr;
        word_t data;
    } store_t;

endpackage

`default_nettype wire

// File: hw/regfile.sv
// Two-read, one-write register file with r0 hard-wired to zero.
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                we_i,
    input  mips_pkg::reg_addr_t waddr_i,
    input  mips_pkg::word_t     wdata_i,
    input  mips_pkg::reg_addr_t raddr1_i,
    input  mips_pkg::reg_addr_t raddr2_i,
    output mips_pkg::word_t     rdata1_o,
    output mips_pkg::word_t     rdata2_o
);
    import mips_pkg::*;

    word_t regs [1:31]; // No storage behind r0.

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Reads are combinational, so a write shows up from the next cycle on.
    assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/mips_pkg.sv
hw/fetch_unit.sv
hw/decode_control.sv
hw/regfile.sv
hw/execute_alu.sv
hw/data_mem.sv
hw/mips_core.sv
bench/mips_assert.sv
bench/mips_tb.sv
